// ==== pipelineGlobalsPkg.sv ====
package pipelineGlobalsPkg;

    localparam int tableWidth       = 128; // one bit per point of the 7-cube
    localparam int fifoDepthDefault = 16;
    localparam int fullnessWidth    = 5;   // holds 0..16
    localparam int sumWidth         = 38;  // 2^35 plus headroom
    localparam int totalWidth       = 40;  // log2(24*2^35) rounded up
    localparam int countWidth       = 5;   // up to 24 per bot

    typedef enum logic [2:0] {
        IDLE,
        LOADPERM,
        SEED,
        GROW,
        EMIT
    } counterState;

    // exchange variables varA and varB of a truth table
    function automatic logic [tableWidth-1:0] varSwap(
        input logic [tableWidth-1:0] tbl,
        input int varA,
        input int varB
    );
        logic [tableWidth-1:0] result;
        int src;
        for (int i = 0; i < tableWidth; i++) begin
            src = i;
            src[varA] = i[varB];
            src[varB] = i[varA];
            result[i] = tbl[src];
        end
        return result;
    endfunction

    // ordering k of variables 4, 5 and 6
    function automatic logic [tableWidth-1:0] permuteLow(
        input logic [tableWidth-1:0] tbl,
        input logic [2:0] k
    );
        logic [tableWidth-1:0] result;
        case (k)
            3'd0:    result = tbl;
            3'd1:    result = varSwap(tbl, 4, 5);
            3'd2:    result = varSwap(tbl, 4, 6);
            3'd3:    result = varSwap(tbl, 5, 6);
            3'd4:    result = varSwap(varSwap(tbl, 4, 5), 4, 6); // 3-cycle
            default: result = varSwap(varSwap(tbl, 4, 6), 4, 5); // inverse 3-cycle
        endcase
        return result;
    endfunction

    // set plus all points one edge away
    function automatic logic [tableWidth-1:0] cubeDilate(input logic [tableWidth-1:0] tbl);
        logic [tableWidth-1:0] result;
        result = tbl;
        for (int v = 0; v < 7; v++) begin
            for (int i = 0; i < tableWidth; i++) begin
                result[i] = result[i] | tbl[i ^ (1 << v)];
            end
        end
        return result;
    endfunction

endpackage

// ==== permuteCheck24.sv ====
`timescale 1ns/1ns

// builds the four swapped variants and flags which of the 24 permutations fit under top
module permuteCheck24 (
    input  logic [pipelineGlobalsPkg::tableWidth-1:0] top,
    input  logic [pipelineGlobalsPkg::tableWidth-1:0] bot,
    input  logic                                      isBotValid,
    output logic [23:0]                               validBotPermutations,
    output logic [pipelineGlobalsPkg::tableWidth-1:0] botABCD,
    output logic [pipelineGlobalsPkg::tableWidth-1:0] botBACD,
    output logic [pipelineGlobalsPkg::tableWidth-1:0] botCBAD,
    output logic [pipelineGlobalsPkg::tableWidth-1:0] botDBCA
);

    logic [pipelineGlobalsPkg::tableWidth-1:0] variants [4];

    assign botABCD = bot; // no swap
    assign botBACD = pipelineGlobalsPkg::varSwap(bot, 3, 4);
    assign botCBAD = pipelineGlobalsPkg::varSwap(bot, 3, 5);
    assign botDBCA = pipelineGlobalsPkg::varSwap(bot, 3, 6);

    assign variants[0] = botABCD;
    assign variants[1] = botBACD;
    assign variants[2] = botCBAD;
    assign variants[3] = botDBCA;

    // ABCD sits in the top six bits, DBCA in the bottom six
    genvar v, k;
    generate
        for (v = 0; v < 4; v++) begin : genVariant
            for (k = 0; k < 6; k++) begin : genOrder
                logic [pipelineGlobalsPkg::tableWidth-1:0] permuted;

                assign permuted = pipelineGlobalsPkg::permuteLow(variants[v], 3'(k));
                // subset test: nothing of the permuted bot outside top
                assign validBotPermutations[(3 - v) * 6 + k] =
                    isBotValid && ((permuted & ~top) == '0);
            end
        end
    endgenerate

endmodule

// ==== botFifo.sv ====
`timescale 1ns/1ns

// circular queue of variant bot and permutation mask, first word falls through
module botFifo #(
    parameter int fifoDepth = pipelineGlobalsPkg::fifoDepthDefault
) (
    input  logic                                         clk,
    input  logic                                         arstN,
    input  logic                                         push,
    input  logic [pipelineGlobalsPkg::tableWidth-1:0]    pushBot,
    input  logic [5:0]                                   pushMask,
    input  logic                                         pop,
    output logic [pipelineGlobalsPkg::tableWidth-1:0]    popBot,
    output logic [5:0]                                   popMask,
    output logic                                         empty,
    output logic [pipelineGlobalsPkg::fullnessWidth-1:0] fullness
);

    localparam int ptrWidth = (fifoDepth > 1) ? $clog2(fifoDepth) : 1;
    localparam logic [ptrWidth-1:0] lastSlot = ptrWidth'(fifoDepth - 1);

    logic [pipelineGlobalsPkg::tableWidth-1:0] botMem [fifoDepth];
    logic [5:0]                                maskMem [fifoDepth];
    logic [ptrWidth-1:0]                       wrPtr;
    logic [ptrWidth-1:0]                       rdPtr;

    always_ff @(posedge clk) begin
        if (push) begin
            botMem[wrPtr]  <= pushBot;
            maskMem[wrPtr] <= pushMask;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            wrPtr    <= '0;
            rdPtr    <= '0;
            fullness <= '0;
        end else begin
            if (push) begin
                wrPtr <= (wrPtr == lastSlot) ? '0 : wrPtr + 1'b1;
            end
            if (pop) begin
                rdPtr <= (rdPtr == lastSlot) ? '0 : rdPtr + 1'b1;
            end
            case ({push, pop})
                2'b10:   fullness <= fullness + 1'b1;
                2'b01:   fullness <= fullness - 1'b1;
                default: ; // both or neither, level unchanged
            endcase
        end
    end

    assign popBot  = botMem[rdPtr];
    assign popMask = maskMem[rdPtr];
    assign empty   = (fullness == '0);

    // the source must hold off on maxFullness, so a full queue never sees a push
    assert property (@(posedge clk) disable iff (!arstN) push |-> fullness < fifoDepth)
        else $error("botFifo push while full");

    assert property (@(posedge clk) disable iff (!arstN) pop |-> !empty)
        else $error("botFifo pop while empty");

endmodule

// ==== componentCounter.sv ====
`timescale 1ns/1ns

// flood-fill component count, one pcoeff per masked permutation
module componentCounter (
    input  logic                                      clk,
    input  logic                                      arstN,
    input  logic [pipelineGlobalsPkg::tableWidth-1:0] top,
    input  logic [pipelineGlobalsPkg::tableWidth-1:0] entryBot,
    input  logic [5:0]                                entryMask,
    input  logic                                      entryValid,
    output logic                                      take,
    output logic                                      done,
    output logic [pipelineGlobalsPkg::sumWidth-1:0]   pcoeff
);

    pipelineGlobalsPkg::counterState state;

    logic [pipelineGlobalsPkg::tableWidth-1:0] entryTable; // variant bot being worked on
    logic [pipelineGlobalsPkg::tableWidth-1:0] remaining;  // points not yet in a component
    logic [pipelineGlobalsPkg::tableWidth-1:0] region;
    logic [pipelineGlobalsPkg::tableWidth-1:0] grown;
    logic [5:0]                                pendMask;   // permutations still to do
    logic [5:0]                                compCount;
    logic [2:0]                                permSel;

    // lowest pending permutation first
    always_comb begin
        permSel = 3'd0;
        for (int k = 5; k >= 0; k--) begin
            if (pendMask[k]) begin
                permSel = 3'(k);
            end
        end
    end

    assign grown  = pipelineGlobalsPkg::cubeDilate(region) & remaining;
    assign take   = (state == pipelineGlobalsPkg::IDLE) && entryValid;
    assign done   = (state == pipelineGlobalsPkg::EMIT);
    assign pcoeff = pipelineGlobalsPkg::sumWidth'(1) << compCount;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state     <= pipelineGlobalsPkg::IDLE;
            pendMask  <= '0;
            compCount <= '0;
        end else begin
            case (state)
                pipelineGlobalsPkg::IDLE: begin
                    if (entryValid) begin
                        pendMask <= entryMask;
                        state    <= pipelineGlobalsPkg::LOADPERM;
                    end
                end
                pipelineGlobalsPkg::LOADPERM: begin
                    if (pendMask == '0) begin
                        state <= pipelineGlobalsPkg::IDLE;
                    end else begin
                        pendMask[permSel] <= 1'b0;
                        compCount         <= '0;
                        state             <= pipelineGlobalsPkg::SEED;
                    end
                end
                pipelineGlobalsPkg::SEED: begin
                    state <= (remaining == '0) ? pipelineGlobalsPkg::EMIT
                                               : pipelineGlobalsPkg::GROW;
                end
                pipelineGlobalsPkg::GROW: begin
                    if (grown == region) begin // component closed
                        compCount <= compCount + 1'b1;
                        state     <= pipelineGlobalsPkg::SEED;
                    end
                end
                default: begin // EMIT
                    state <= (pendMask != '0) ? pipelineGlobalsPkg::LOADPERM
                                              : pipelineGlobalsPkg::IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            pipelineGlobalsPkg::IDLE: begin
                if (entryValid) begin
                    entryTable <= entryBot;
                end
            end
            pipelineGlobalsPkg::LOADPERM: begin
                remaining <= top & ~pipelineGlobalsPkg::permuteLow(entryTable, permSel);
            end
            pipelineGlobalsPkg::SEED: begin
                region <= remaining & (~remaining + 1'b1); // isolate lowest point
            end
            pipelineGlobalsPkg::GROW: begin
                if (grown == region) begin
                    remaining <= remaining & ~region;
                end else begin
                    region <= grown;
                end
            end
            default: ;
        endcase
    end

    // monotone inputs keep this bound, and it sizes the pipeline sum
    assert property (@(posedge clk) disable iff (!arstN) compCount <= 6'd35)
        else $error("componentCounter count above 35");

endmodule

// ==== fullPipeline.sv ====
`timescale 1ns/1ns

// one swap variant: queue, component counter and registered result
module fullPipeline #(
    parameter int fifoDepth = pipelineGlobalsPkg::fifoDepthDefault
) (
    input  logic                                         clk,
    input  logic                                         arstN,
    input  logic [pipelineGlobalsPkg::tableWidth-1:0]    top,
    input  logic [pipelineGlobalsPkg::tableWidth-1:0]    bot,
    input  logic                                         isBotValid,
    input  logic [5:0]                                   validPermutations,
    output logic [pipelineGlobalsPkg::fullnessWidth-1:0] fullness,
    output logic [pipelineGlobalsPkg::sumWidth-1:0]      sum,
    output logic [2:0]                                   count
);

    logic                                       push;
    logic                                       take;
    logic                                       empty;
    logic                                       done;
    logic [pipelineGlobalsPkg::tableWidth-1:0]  entryBot;
    logic [5:0]                                 entryMask;
    logic [pipelineGlobalsPkg::sumWidth-1:0]    pcoeff;

    assign push = isBotValid && (validPermutations != '0); // empty masks are dropped

    botFifo #(.fifoDepth(fifoDepth)) u_botFifo (
        .clk      (clk),
        .arstN    (arstN),
        .push     (push),
        .pushBot  (bot),
        .pushMask (validPermutations),
        .pop      (take),
        .popBot   (entryBot),
        .popMask  (entryMask),
        .empty    (empty),
        .fullness (fullness)
    );

    componentCounter u_componentCounter (
        .clk        (clk),
        .arstN      (arstN),
        .top        (top),
        .entryBot   (entryBot),
        .entryMask  (entryMask),
        .entryValid (!empty),
        .take       (take),
        .done       (done),
        .pcoeff     (pcoeff)
    );

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            sum   <= '0;
            count <= '0;
        end else begin
            sum   <= done ? pcoeff : '0;
            count <= done ? 3'd1 : 3'd0;
        end
    end

endmodule

// ==== pipeline24Pack.sv ====
`timescale 1ns/1ns

// sums the P-coefficients of all 24 permutations of variables 3..6
module pipeline24Pack #(
    parameter int fifoDepth = pipelineGlobalsPkg::fifoDepthDefault
) (
    input  logic                                         clk,
    input  logic                                         arstN,
    input  logic [pipelineGlobalsPkg::tableWidth-1:0]    top,
    input  logic [pipelineGlobalsPkg::tableWidth-1:0]    bot,
    input  logic                                         isBotValid,
    output logic [pipelineGlobalsPkg::fullnessWidth-1:0] maxFullness,
    output logic [pipelineGlobalsPkg::totalWidth-1:0]    summedData,
    output logic [pipelineGlobalsPkg::countWidth-1:0]    pcoeffCount
);

    logic [pipelineGlobalsPkg::tableWidth-1:0]    variantBots [4];
    logic [23:0]                                  validPerms;
    logic [pipelineGlobalsPkg::sumWidth-1:0]      sums [4];
    logic [2:0]                                   counts [4];
    logic [pipelineGlobalsPkg::fullnessWidth-1:0] fullnesses [4];
    logic [pipelineGlobalsPkg::fullnessWidth-1:0] maxFullness01;
    logic [pipelineGlobalsPkg::fullnessWidth-1:0] maxFullness23;

    permuteCheck24 u_permuteCheck24 (
        .top                  (top),
        .bot                  (bot),
        .isBotValid           (isBotValid),
        .validBotPermutations (validPerms),
        .botABCD              (variantBots[0]),
        .botBACD              (variantBots[1]),
        .botCBAD              (variantBots[2]),
        .botDBCA              (variantBots[3])
    );

    genvar p;
    generate
        for (p = 0; p < 4; p++) begin : genPipe
            fullPipeline #(.fifoDepth(fifoDepth)) u_fullPipeline (
                .clk               (clk),
                .arstN             (arstN),
                .top               (top),
                .bot               (variantBots[p]),
                .isBotValid        (isBotValid),
                .validPermutations (validPerms[(3 - p) * 6 +: 6]),
                .fullness          (fullnesses[p]),
                .sum               (sums[p]),
                .count             (counts[p])
            );
        end
    endgenerate

    assign summedData =
        (pipelineGlobalsPkg::totalWidth'(sums[0]) + pipelineGlobalsPkg::totalWidth'(sums[1])) +
        (pipelineGlobalsPkg::totalWidth'(sums[2]) + pipelineGlobalsPkg::totalWidth'(sums[3]));
    assign pcoeffCount =
        (pipelineGlobalsPkg::countWidth'(counts[0]) + pipelineGlobalsPkg::countWidth'(counts[1])) +
        (pipelineGlobalsPkg::countWidth'(counts[2]) + pipelineGlobalsPkg::countWidth'(counts[3]));

    // two-level max tree
    assign maxFullness01 = (fullnesses[0] > fullnesses[1]) ? fullnesses[0] : fullnesses[1];
    assign maxFullness23 = (fullnesses[2] > fullnesses[3]) ? fullnesses[2] : fullnesses[3];
    assign maxFullness   = (maxFullness01 > maxFullness23) ? maxFullness01 : maxFullness23;

endmodule

// ==== tbModel.svh ====
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// 32-bit LCG step
function automatic logic [31:0] lcgNext(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
endfunction

// add every point below a set point, giving a monotone table
function automatic logic [127:0] closeDown(input logic [127:0] t);
    logic [127:0] r;
    r = t;
    for (int i = 127; i >= 0; i--) begin // high to low so chains propagate
        for (int v = 0; v < 7; v++) begin
            if (r[i] && i[v]) begin
                r[i & ~(1 << v)] = 1'b1;
            end
        end
    end
    return r;
endfunction

// variables 3..6 of tbl land on positions p3..p6
function automatic logic [127:0] remapVars(input logic [127:0] tbl,
                                           input int p3, input int p4,
                                           input int p5, input int p6);
    logic [127:0] r;
    int j;
    for (int i = 0; i < 128; i++) begin
        j = i & 7;
        j |= ((i >> 3) & 1) << p3;
        j |= ((i >> 4) & 1) << p4;
        j |= ((i >> 5) & 1) << p5;
        j |= ((i >> 6) & 1) << p6;
        r[i] = tbl[j];
    end
    return r;
endfunction

// depth-first walk over single-bit neighbours
function automatic int countComponents(input logic [127:0] s);
    logic [127:0] seen;
    int stack [128];
    int sp;
    int cur;
    int nb;
    int n;
    seen = '0;
    n = 0;
    for (int i = 0; i < 128; i++) begin
        if (s[i] && !seen[i]) begin
            n++;
            seen[i] = 1'b1;
            stack[0] = i;
            sp = 1;
            while (sp > 0) begin
                sp--;
                cur = stack[sp];
                for (int v = 0; v < 7; v++) begin
                    nb = cur ^ (1 << v);
                    if (s[nb] && !seen[nb]) begin
                        seen[nb] = 1'b1;
                        stack[sp] = nb;
                        sp++;
                    end
                end
            end
        end
    end
    return n;
endfunction

// all 24 orderings of variables 3..6, in any order since only totals matter
task automatic predictBot(input logic [127:0] t, input logic [127:0] b,
                          output int nValid, output longint pSum);
    logic [127:0] pb;
    nValid = 0;
    pSum = 0;
    for (int a = 3; a < 7; a++) begin
        for (int c = 3; c < 7; c++) begin
            for (int d = 3; d < 7; d++) begin
                if (a != c && a != d && c != d) begin
                    pb = remapVars(b, a, c, d, 18 - a - c - d); // last one is what is left
                    if ((pb & ~t) == '0) begin
                        nValid++;
                        pSum += longint'(1) << countComponents(t & ~pb);
                    end
                end
            end
        end
    end
endtask

`endif

// ==== tbPipeline24Pack.sv ====
`timescale 1ns/1ns

module tbPipeline24Pack;

    localparam int tbDepth        = 4; // small queues so the source really stalls
    localparam int randBots       = 40;
    localparam int burstBots      = 24;
    localparam int totalBots      = randBots + burstBots + 2;
    localparam int drainLimit     = burstBots * 64 * 200;
    localparam int watchdogCycles = totalBots * 64 * 200 + 2000;

    logic                                         clk;
    logic                                         arstN;
    logic [127:0]                                 top;
    logic [127:0]                                 bot;
    logic                                         isBotValid;
    logic [pipelineGlobalsPkg::fullnessWidth-1:0] maxFullness;
    logic [pipelineGlobalsPkg::totalWidth-1:0]    summedData;
    logic [pipelineGlobalsPkg::countWidth-1:0]    pcoeffCount;

    logic [31:0] rngState;
    logic        expectIdle; // no queue use and no output expected
    logic [pipelineGlobalsPkg::fullnessWidth-1:0] fullnessSeen; // level ahead of the next edge
    int          errorCount;
    int          botsSent;
    int          accCount;
    int          expCount;
    longint      accSum;
    longint      expSum;

    `include "tbModel.svh"

    pipeline24Pack #(.fifoDepth(tbDepth)) u_pipeline24Pack (
        .clk         (clk),
        .arstN       (arstN),
        .top         (top),
        .bot         (bot),
        .isBotValid  (isBotValid),
        .maxFullness (maxFullness),
        .summedData  (summedData),
        .pcoeffCount (pcoeffCount)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // totals picked up on the falling edge, away from the drive edge
    always @(negedge clk) begin
        fullnessSeen = maxFullness;
        if (arstN) begin
            accSum   = accSum + longint'(summedData);
            accCount = accCount + int'(pcoeffCount);
        end
    end

    assert property (@(posedge clk) disable iff (!arstN) pcoeffCount <= 5'd4)
        else begin
            errorCount++;
            $display("Mismatch pcoeffCount 0x%0h above limit 0x4", pcoeffCount);
        end

    assert property (@(posedge clk) disable iff (!arstN) maxFullness <= tbDepth)
        else begin
            errorCount++;
            $display("Mismatch maxFullness 0x%0h above depth 0x%0h", maxFullness, tbDepth);
        end

    assert property (@(posedge clk) disable iff (!arstN)
        expectIdle |-> (summedData == '0 && pcoeffCount == '0 && maxFullness == '0))
        else begin
            errorCount++;
            $display("Mismatch idle outputs summedData 0x%0h pcoeffCount 0x%0h maxFullness 0x%0h",
                     summedData, pcoeffCount, maxFullness);
        end

    function automatic logic [127:0] randomDownSet(input int nPoints);
        logic [127:0] t;
        logic [6:0]   pt;
        t = '0;
        for (int n = 0; n < nPoints; n++) begin
            rngState = lcgNext(rngState);
            pt = rngState[22:16];
            t[pt == 7'h7f ? 7'h3f : pt] = 1'b1; // keep the all-ones point out
        end
        return closeDown(t);
    endfunction

    function automatic logic [127:0] randomBot();
        logic [127:0] b;
        b = randomDownSet(2);
        rngState = lcgNext(rngState);
        if (rngState[30]) begin
            b = b & top; // raises the share of valid permutations
        end
        return b;
    endfunction

    // one strobe, held off while any queue is nearly full
    task automatic sendBot(input logic [127:0] b);
        while (fullnessSeen >= tbDepth - 1) begin
            isBotValid <= 1'b0;
            @(posedge clk);
        end
        bot        <= b;
        isBotValid <= 1'b1;
        botsSent++;
        @(posedge clk);
    endtask

    task automatic compareTotals(input string phase);
        assert (accCount == expCount)
            else begin
                errorCount++;
                $display("Mismatch pcoeffCount total after %s got 0x%0h expected 0x%0h",
                         phase, accCount, expCount);
            end
        assert (accSum == expSum)
            else begin
                errorCount++;
                $display("Mismatch summedData total after %s got 0x%0h expected 0x%0h",
                         phase, accSum, expSum);
            end
    endtask

    // wait until every expected pcoeff has come out and the queues are empty
    task automatic drainPipes(input string phase);
        int waited;
        isBotValid <= 1'b0;
        waited = 0;
        while ((accCount != expCount || maxFullness != '0) && waited < drainLimit) begin
            @(posedge clk);
            waited++;
        end
        if (waited >= drainLimit) begin
            errorCount++;
            $display("Pipelines did not drain after %s", phase);
        end
        repeat (2) @(posedge clk);
        compareTotals(phase);
    endtask

    initial begin
        logic [127:0] b;
        int           vCount;
        longint       vSum;
        rngState   = 32'h87ad;
        arstN      = 1'b0;
        bot        = '0;
        isBotValid = 1'b0;
        expectIdle = 1'b1;
        fullnessSeen = '0;
        errorCount = 0;
        botsSent   = 0;
        accCount   = 0;
        expCount   = 0;
        accSum     = 0;
        expSum     = 0;
        top        = randomDownSet(6); // fixed for the whole run
        repeat (3) @(posedge clk);
        arstN <= 1'b1;
        repeat (5) @(posedge clk); // quiet window after reset

        // empty bot fits under top in all 24 orderings
        expCount += 24;
        expSum += 24 * (longint'(1) << countComponents(top));
        expectIdle <= 1'b0;
        sendBot('0);
        drainPipes("zero bot");

        // full table never fits, nothing may be queued
        expectIdle <= 1'b1;
        sendBot('1);
        isBotValid <= 1'b0;
        repeat (20) @(posedge clk);
        compareTotals("no-fit bot");
        expectIdle <= 1'b0;

        for (int n = 0; n < randBots; n++) begin
            b = randomBot();
            predictBot(top, b, vCount, vSum);
            expCount += vCount;
            expSum += vSum;
            sendBot(b);
            isBotValid <= 1'b0;
            repeat (rngState[27:24]) @(posedge clk); // random gap
        end
        drainPipes("random stream");

        // back to back, only the fullness limit holds the source back
        for (int n = 0; n < burstBots; n++) begin
            b = randomBot();
            predictBot(top, b, vCount, vSum);
            expCount += vCount;
            expSum += vSum;
            sendBot(b);
        end
        drainPipes("burst");

        $display("Run finished: %0d bots sent, %0d errors", botsSent, errorCount);
        if (errorCount == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        repeat (watchdogCycles) @(posedge clk);
        $display("Watchdog expired after %0d cycles with %0d errors", watchdogCycles, errorCount);
        $display("Simulation failed");
        $finish;
    end

endmodule

// ==== src.f ====
+incdir+.
pipelineGlobalsPkg.sv
permuteCheck24.sv
botFifo.sv
componentCounter.sv
fullPipeline.sv
pipeline24Pack.sv
tbPipeline24Pack.sv

// ==== run.sh ====
#!/bin/bash
set -eo pipefail
cd "$(dirname "$0")"

verilator --binary --assert --timing -Wno-fatal -f src.f \
    --top-module tbPipeline24Pack -o simTb
./obj_dir/simTb | tee sim.log

if grep -q "Simulation failed" sim.log; then
    echo "testbench reported failure, see sim.log"
    exit 1
fi
echo "testbench passed"
